//--- design/oram_config.svh
//--------------------------------------------------------------------
// Path ORAM configuration
// Tree shape, block widths, stash size and cipher key
//--------------------------------------------------------------------
`ifndef ORAM_CONFIG_SVH
`define ORAM_CONFIG_SVH

// Levels below the root (4 levels, 8 leaves)
`define ORAM_L 3

// Slots per bucket
`define ORAM_Z 2

// Block address and data widths
`define ORAM_U 6
`define ORAM_D 16

// Stash entries and total buckets in the tree
`define ORAM_STASH 24
`define ORAM_BUCKETS 15

// Key mixed into every bucket pad
`define ORAM_KEY 32'h5a3c_96e1

`endif

//--- design/oramPkg.sv
//--------------------------------------------------------------------
// Path ORAM shared types
//--------------------------------------------------------------------
package oramPkg;
	`include "oram_config.svh"

	typedef logic [`ORAM_U-1:0] pAddrT;
	typedef logic [`ORAM_L-1:0] leafT;
	typedef logic [`ORAM_D-1:0] blockDataT;
	// Heap index of a bucket, root is 0
	typedef logic [3:0] bucketAddrT;
	typedef logic [4:0] stashIdxT;

	// One block slot as stored in a bucket
	typedef struct packed {
		logic      valid;
		pAddrT     pAddr;
		leafT      leaf;
		blockDataT data;
	} oramSlotT;

	// DRAM data word
	typedef struct packed {
		oramSlotT [`ORAM_Z-1:0] slot;
	} bucketT;

	typedef struct packed {
		logic       isWrite;
		bucketAddrT addr;
	} dramCmdT;

	typedef enum logic {
		cmdRead,
		cmdWrite
	} beCmdE;

	typedef enum logic [2:0] {
		stInit,
		stIdle,
		stReadPath,
		stServe,
		stWritePath
	} backendStateE;
endpackage

//--- design/oramStash.sv
//--------------------------------------------------------------------
// Path ORAM stash
// Block insert, address lookup and update, per-level eviction select
//--------------------------------------------------------------------
`timescale 1ns/1ns
`include "oram_config.svh"

module oramStash (
	input  logic               Clock,
	input  logic               rstN,
	input  logic               insValid,
	input  oramPkg::oramSlotT  insSlot,
	input  oramPkg::pAddrT     lookAddr,
	output logic               lookHit,
	output oramPkg::stashIdxT  lookIdx,
	output oramPkg::blockDataT lookData,
	input  logic               updValid,
	input  oramPkg::blockDataT updData,
	input  oramPkg::leafT      updLeaf,
	input  oramPkg::pAddrT     updAddr,
	input  oramPkg::leafT      evictLeaf,
	input  logic [1:0]         evictLevel,
	output oramPkg::bucketT    evictBucket,
	input  logic               evictCommit,
	output oramPkg::stashIdxT  occupancy
);
	import oramPkg::*;

	localparam int N = `ORAM_STASH;
	localparam int SelW = $clog2(`ORAM_Z);

	logic [N-1:0] entValid;
	pAddrT        entAddr [N];
	leafT         entLeaf [N];
	blockDataT    entData [N];

	logic         freeHit;
	stashIdxT     freeIdx;
	logic         matchHit;
	stashIdxT     matchIdx;
	logic [N-1:0] selMask;
	logic [N-1:0] selNext;
	bucketT       bktNext;
	logic         allocIns;
	logic         allocUpd;

	//------------------------------------------------------------------
	// Entry search
	//------------------------------------------------------------------

	// Lowest free entry
	always_comb begin
		freeHit = 1'b0;
		freeIdx = '0;
		for (int i = N - 1; i >= 0; i--) begin
			if (!entValid[i]) begin
				freeHit = 1'b1;
				freeIdx = stashIdxT'(i);
			end
		end
	end

	// Lowest entry holding lookAddr
	always_comb begin
		matchHit = 1'b0;
		matchIdx = '0;
		for (int i = N - 1; i >= 0; i--) begin
			if (entValid[i] && entAddr[i] == lookAddr) begin
				matchHit = 1'b1;
				matchIdx = stashIdxT'(i);
			end
		end
	end

	// First Z blocks whose path meets the target leaf at evictLevel
	always_comb begin
		logic [SelW:0] taken;
		int unsigned   shift;
		taken = '0;
		shift = `ORAM_L - int'(evictLevel);
		selNext = '0;
		bktNext = '0;
		for (int i = 0; i < N; i++) begin
			if (entValid[i] && (entLeaf[i] >> shift) == (evictLeaf >> shift)
					&& taken < (SelW+1)'(`ORAM_Z)) begin
				selNext[i] = 1'b1;
				bktNext.slot[taken[SelW-1:0]] = '{valid: 1'b1, pAddr: entAddr[i],
					leaf: entLeaf[i], data: entData[i]};
				taken = taken + 1'b1;
			end
		end
	end

	always_comb begin
		occupancy = '0;
		for (int i = 0; i < N; i++) begin
			occupancy = occupancy + stashIdxT'(entValid[i]);
		end
	end

	// Empty slots from the path are dropped
	assign allocIns = insValid && insSlot.valid && freeHit;
	// Update on a lookup miss creates the block
	assign allocUpd = updValid && !lookHit && freeHit;

	//------------------------------------------------------------------
	// State
	//------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			entValid <= '0;
			selMask  <= '0;
			lookHit  <= 1'b0;
			lookIdx  <= '0;
		end else begin
			selMask <= selNext;
			lookHit <= matchHit;
			lookIdx <= matchIdx;
			if (evictCommit) begin
				entValid <= entValid & ~selMask;
			end
			if (allocIns || allocUpd) begin
				entValid[freeIdx] <= 1'b1;
			end
		end
	end

	// Payload updates land on the entry found by the last lookup
	always_ff @(posedge Clock) begin
		lookData    <= entData[matchIdx];
		evictBucket <= bktNext;
		if (allocIns) begin
			entAddr[freeIdx] <= insSlot.pAddr;
			entLeaf[freeIdx] <= insSlot.leaf;
			entData[freeIdx] <= insSlot.data;
		end
		if (updValid && lookHit) begin
			entLeaf[lookIdx] <= updLeaf;
			entData[lookIdx] <= updData;
		end else if (allocUpd) begin
			entAddr[freeIdx] <= updAddr;
			entLeaf[freeIdx] <= updLeaf;
			entData[freeIdx] <= updData;
		end
	end
endmodule

//--- design/backendInner.sv
//--------------------------------------------------------------------
// Path ORAM access controller
// Init sweep, path read, frontend service and path writeback
//--------------------------------------------------------------------
`timescale 1ns/1ns
`include "oram_config.svh"

module backendInner (
	input  logic                Clock,
	input  logic                rstN,
	input  oramPkg::beCmdE      cmd,
	input  oramPkg::pAddrT      pAddr,
	input  oramPkg::leafT       currentLeaf,
	input  oramPkg::leafT       remappedLeaf,
	input  logic                cmdValid,
	output logic                cmdReady,
	output oramPkg::blockDataT  loadData,
	output logic                loadValid,
	input  logic                loadReady,
	input  oramPkg::blockDataT  storeData,
	input  logic                storeValid,
	output logic                storeReady,
	output oramPkg::dramCmdT    dramCmd,
	output logic                dramCmdValid,
	input  logic                dramCmdReady,
	input  oramPkg::bucketT     rdData,
	input  logic                rdValid,
	output logic                rdReady,
	output oramPkg::bucketT     wrData,
	output oramPkg::bucketAddrT wrAddr,
	output logic                wrValid,
	input  logic                wrReady
);
	import oramPkg::*;

	localparam int SelW = $clog2(`ORAM_Z);
	localparam logic [2:0] PathLen = 3'(`ORAM_L + 1);

	backendStateE    state;
	beCmdE           reqCmd;
	pAddrT           reqAddr;
	leafT            reqLeaf;
	leafT            newLeaf;
	logic [2:0]      issueCnt;
	logic [2:0]      retCnt;
	bucketT          rdBuf;
	logic            bufFull;
	logic [SelW-1:0] insSel;
	logic [1:0]      wrLvl;
	bucketAddrT      initIdx;
	logic            issueWait;
	logic            cmdDone;
	logic            wrDone;

	logic            issuing;
	logic            cmdFire;
	logic            wrFire;
	logic            rdFire;
	logic            bucketDone;
	logic            stashHit;
	blockDataT       stashData;
	bucketT          stashEvict;
	stashIdxT        stashOccupancy;
	logic            insValid;
	oramSlotT        insSlot;
	logic            updValid;
	blockDataT       updData;
	logic            evictCommit;

	// Heap index of the path bucket at a level
	function automatic bucketAddrT levelBucket(input leafT leaf, input logic [1:0] lvl);
		logic [3:0] offs;
		offs = 4'(leaf) >> (`ORAM_L - int'(lvl));
		levelBucket = bucketAddrT'((4'd1 << lvl) - 4'd1 + offs);
	endfunction

	//------------------------------------------------------------------
	// Handshakes
	//------------------------------------------------------------------

	// Bucket writes, during init and eviction
	assign issuing    = (state == stInit || state == stWritePath) && !issueWait;
	assign cmdFire    = dramCmdValid && dramCmdReady;
	assign wrFire     = wrValid && wrReady;
	assign rdFire     = rdValid && rdReady;
	assign bucketDone = (cmdDone || cmdFire) && (wrDone || wrFire);

	assign cmdReady     = state == stIdle;
	assign rdReady      = state == stReadPath && !bufFull;
	assign dramCmdValid = (state == stReadPath && issueCnt != PathLen) || (issuing && !cmdDone);
	assign wrValid      = issuing && !wrDone;
	assign wrAddr       = (state == stInit) ? initIdx : levelBucket(reqLeaf, wrLvl);
	assign wrData       = (state == stInit) ? '0 : stashEvict;

	always_comb begin
		if (state == stReadPath) begin
			dramCmd.isWrite = 1'b0;
			dramCmd.addr    = levelBucket(reqLeaf, issueCnt[1:0]);
		end else begin
			dramCmd.isWrite = 1'b1;
			dramCmd.addr    = wrAddr;
		end
	end

	// Blocks never stored read back as zero
	assign loadData   = stashHit ? stashData : '0;
	assign loadValid  = state == stServe && reqCmd == cmdRead;
	assign storeReady = state == stServe && reqCmd == cmdWrite;

	assign insValid    = bufFull;
	assign insSlot     = rdBuf.slot[insSel];
	assign updValid    = (loadValid && loadReady) || (storeValid && storeReady);
	assign updData     = (reqCmd == cmdWrite) ? storeData : loadData;
	assign evictCommit = state == stWritePath && issuing && bucketDone;

	//------------------------------------------------------------------
	// Controller
	//------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state     <= stInit;
			issueCnt  <= '0;
			retCnt    <= '0;
			bufFull   <= 1'b0;
			insSel    <= '0;
			wrLvl     <= '0;
			initIdx   <= '0;
			issueWait <= 1'b1;
			cmdDone   <= 1'b0;
			wrDone    <= 1'b0;
		end else begin
			if (issuing) begin
				if (bucketDone) begin
					cmdDone <= 1'b0;
					wrDone  <= 1'b0;
				end else begin
					cmdDone <= cmdDone | cmdFire;
					wrDone  <= wrDone | wrFire;
				end
			end
			// One slot of the buffered bucket per cycle into the stash
			if (bufFull) begin
				insSel <= insSel + 1'b1;
				if (insSel == SelW'(`ORAM_Z - 1)) begin
					bufFull <= 1'b0;
					insSel  <= '0;
				end
			end
			if (rdFire) begin
				bufFull <= 1'b1;
				retCnt  <= retCnt + 1'b1;
			end
			case (state)
				stInit: begin
					issueWait <= 1'b0;
					if (issuing && bucketDone) begin
						initIdx <= initIdx + 1'b1;
						if (initIdx == bucketAddrT'(`ORAM_BUCKETS - 1)) begin
							state <= stIdle;
						end
					end
				end
				stIdle: begin
					if (cmdValid) begin
						state    <= stReadPath;
						issueCnt <= '0;
						retCnt   <= '0;
					end
				end
				stReadPath: begin
					if (cmdFire) begin
						issueCnt <= issueCnt + 1'b1;
					end
					if (retCnt == PathLen && !bufFull) begin
						state <= stServe;
					end
				end
				stServe: begin
					if (updValid) begin
						state     <= stWritePath;
						wrLvl     <= 2'(`ORAM_L);
						issueWait <= 1'b1;
					end
				end
				stWritePath: begin
					// Wait a cycle so the stash selects for the new level
					if (issueWait) begin
						issueWait <= 1'b0;
					end else if (bucketDone) begin
						issueWait <= 1'b1;
						if (wrLvl == 2'd0) begin
							state <= stIdle;
						end else begin
							wrLvl <= wrLvl - 1'b1;
						end
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// Request held for the whole access
	always_ff @(posedge Clock) begin
		if (cmdValid && cmdReady) begin
			reqCmd  <= cmd;
			reqAddr <= pAddr;
			reqLeaf <= currentLeaf;
			newLeaf <= remappedLeaf;
		end
		if (rdFire) begin
			rdBuf <= rdData;
		end
	end

	oramStash u_oramStash (
		.Clock       (Clock),
		.rstN        (rstN),
		.insValid    (insValid),
		.insSlot     (insSlot),
		.lookAddr    (reqAddr),
		.lookHit     (stashHit),
		.lookIdx     (),
		.lookData    (stashData),
		.updValid    (updValid),
		.updData     (updData),
		.updLeaf     (newLeaf),
		.updAddr     (reqAddr),
		.evictLeaf   (reqLeaf),
		.evictLevel  (wrLvl),
		.evictBucket (stashEvict),
		.evictCommit (evictCommit),
		.occupancy   (stashOccupancy)
	);
endmodule

//--- design/bucketCipher.sv
//--------------------------------------------------------------------
// Bucket cipher
// Keyed pad XOR on DRAM reads and writes
//--------------------------------------------------------------------
`timescale 1ns/1ns
`include "oram_config.svh"

module bucketCipher (
	input  logic                Clock,
	input  logic                rstN,
	input  oramPkg::dramCmdT    cmd,
	input  logic                cmdFire,
	output oramPkg::bucketT     beRdData,
	output logic                beRdValid,
	input  logic                beRdReady,
	input  oramPkg::bucketT     beWrData,
	input  oramPkg::bucketAddrT beWrAddr,
	input  logic                beWrValid,
	output logic                beWrReady,
	input  oramPkg::bucketT     dramReadData,
	input  logic                dramReadValid,
	output logic                dramReadReady,
	output oramPkg::bucketT     dramWriteData,
	output logic                dramWriteValid,
	input  logic                dramWriteReady
);
	import oramPkg::*;

	// Read addresses in command order
	bucketAddrT rdQueue [4];
	logic [1:0] headPtr;
	logic [1:0] tailPtr;

	// Pad for one bucket index
	function automatic bucketT padFor(input bucketAddrT b);
		logic [31:0] h0;
		logic [31:0] h1;
		h0 = `ORAM_KEY ^ ({28'd0, b} * 32'h9e37_79b9);
		h0 = h0 ^ (h0 >> 15);
		h1 = h0 * 32'h85eb_ca6b;
		h1 = h1 ^ (h1 >> 13);
		padFor = {h1[19:0], h0};
	endfunction

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			headPtr <= '0;
			tailPtr <= '0;
		end else begin
			if (cmdFire && !cmd.isWrite) begin
				tailPtr <= tailPtr + 1'b1;
			end
			if (dramReadValid && beRdReady) begin
				headPtr <= headPtr + 1'b1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (cmdFire && !cmd.isWrite) begin
			rdQueue[tailPtr] <= cmd.addr;
		end
	end

	assign beRdData      = dramReadData ^ padFor(rdQueue[headPtr]);
	assign beRdValid     = dramReadValid;
	assign dramReadReady = beRdReady;

	assign dramWriteData  = beWrData ^ padFor(beWrAddr);
	assign dramWriteValid = beWrValid;
	assign beWrReady      = dramWriteReady;
endmodule

//--- design/pathOramBackend.sv
//--------------------------------------------------------------------
// Path ORAM backend top
//--------------------------------------------------------------------
`timescale 1ns/1ns

module pathOramBackend (
	input  logic               Clock,
	input  logic               rstN,
	input  oramPkg::beCmdE     cmd,
	input  oramPkg::pAddrT     pAddr,
	input  oramPkg::leafT      currentLeaf,
	input  oramPkg::leafT      remappedLeaf,
	input  logic               cmdValid,
	output logic               cmdReady,
	output oramPkg::blockDataT loadData,
	output logic               loadValid,
	input  logic               loadReady,
	input  oramPkg::blockDataT storeData,
	input  logic               storeValid,
	output logic               storeReady,
	output oramPkg::dramCmdT   dramCmd,
	output logic               dramCmdValid,
	input  logic               dramCmdReady,
	input  oramPkg::bucketT    dramReadData,
	input  logic               dramReadValid,
	output logic               dramReadReady,
	output oramPkg::bucketT    dramWriteData,
	output logic               dramWriteValid,
	input  logic               dramWriteReady
);
	import oramPkg::*;

	// Plaintext side of the cipher
	bucketT     beRdData;
	logic       beRdValid;
	logic       beRdReady;
	bucketT     beWrData;
	bucketAddrT beWrAddr;
	logic       beWrValid;
	logic       beWrReady;
	logic       dramCmdFire;

	assign dramCmdFire = dramCmdValid & dramCmdReady;

	backendInner u_backendInner (
		.Clock        (Clock),
		.rstN         (rstN),
		.cmd          (cmd),
		.pAddr        (pAddr),
		.currentLeaf  (currentLeaf),
		.remappedLeaf (remappedLeaf),
		.cmdValid     (cmdValid),
		.cmdReady     (cmdReady),
		.loadData     (loadData),
		.loadValid    (loadValid),
		.loadReady    (loadReady),
		.storeData    (storeData),
		.storeValid   (storeValid),
		.storeReady   (storeReady),
		.dramCmd      (dramCmd),
		.dramCmdValid (dramCmdValid),
		.dramCmdReady (dramCmdReady),
		.rdData       (beRdData),
		.rdValid      (beRdValid),
		.rdReady      (beRdReady),
		.wrData       (beWrData),
		.wrAddr       (beWrAddr),
		.wrValid      (beWrValid),
		.wrReady      (beWrReady)
	);

	bucketCipher u_bucketCipher (
		.Clock          (Clock),
		.rstN           (rstN),
		.cmd            (dramCmd),
		.cmdFire        (dramCmdFire),
		.beRdData       (beRdData),
		.beRdValid      (beRdValid),
		.beRdReady      (beRdReady),
		.beWrData       (beWrData),
		.beWrAddr       (beWrAddr),
		.beWrValid      (beWrValid),
		.beWrReady      (beWrReady),
		.dramReadData   (dramReadData),
		.dramReadValid  (dramReadValid),
		.dramReadReady  (dramReadReady),
		.dramWriteData  (dramWriteData),
		.dramWriteValid (dramWriteValid),
		.dramWriteReady (dramWriteReady)
	);
endmodule

//--- dv/tbClock.sv
//--------------------------------------------------------------------
// Testbench clock source, 20 ns period
//--------------------------------------------------------------------
`timescale 1ns/1ns

module tbClock #(
	parameter int PeriodNs = 20
) (
	output logic Clock
);
	initial begin
		Clock = 1'b0;
		forever #(PeriodNs / 2) Clock = ~Clock;
	end
endmodule

//--- dv/dramModel.sv
//--------------------------------------------------------------------
// Behavioural DRAM bucket memory
// Random ready back-pressure, read data returned in command order
//--------------------------------------------------------------------
`timescale 1ns/1ns
`include "oram_config.svh"

module dramModel #(
	parameter logic [31:0] Seed = 32'h794c
) (
	input  logic             Clock,
	input  logic             rstN,
	input  oramPkg::dramCmdT dramCmd,
	input  logic             dramCmdValid,
	output logic             dramCmdReady,
	output oramPkg::bucketT  dramReadData,
	output logic             dramReadValid,
	input  logic             dramReadReady,
	input  oramPkg::bucketT  dramWriteData,
	input  logic             dramWriteValid,
	output logic             dramWriteReady
);
	import oramPkg::*;

	integer     seed;
	bucketT     mem [`ORAM_BUCKETS];
	bucketAddrT rdQ [$];
	bucketAddrT wrAddrQ [$];
	bucketT     wrDataQ [$];
	logic       running;
	logic       rdFire;

	initial begin
		seed           = Seed;
		dramCmdReady   = 1'b0;
		dramWriteReady = 1'b0;
		dramReadValid  = 1'b0;
		dramReadData   = '0;
		// Power-up contents, overwritten by the init sweep
		for (int i = 0; i < `ORAM_BUCKETS; i++) begin
			mem[i] = {13{bucketAddrT'(i)}};
		end
	end

	always @(posedge Clock) begin
		running = (rstN === 1'b1);
		rdFire  = dramReadValid && dramReadReady;
		if (!running) begin
			rdQ.delete();
			wrAddrQ.delete();
			wrDataQ.delete();
		end else begin
			if (dramCmdValid && dramCmdReady) begin
				if (dramCmd.isWrite) begin
					wrAddrQ.push_back(dramCmd.addr);
				end else begin
					rdQ.push_back(dramCmd.addr);
				end
			end
			if (dramWriteValid && dramWriteReady) begin
				wrDataQ.push_back(dramWriteData);
			end
			// Command and data of a write may arrive in different cycles
			if (wrAddrQ.size() != 0 && wrDataQ.size() != 0) begin
				mem[wrAddrQ.pop_front()] = wrDataQ.pop_front();
			end
			if (rdFire) begin
				void'(rdQ.pop_front());
			end
		end
		#2;
		if (!running) begin
			dramCmdReady   = 1'b0;
			dramWriteReady = 1'b0;
			dramReadValid  = 1'b0;
		end else begin
			dramCmdReady   = ($random(seed) & 3) != 0;
			dramWriteReady = ($random(seed) & 3) != 0;
			// Read valid holds with its data until accepted
			if (rdFire || !dramReadValid) begin
				dramReadValid = rdQ.size() != 0 && ($random(seed) & 1) != 0;
				dramReadData  = (rdQ.size() != 0) ? mem[rdQ[0]] : '0;
			end
		end
	end
endmodule

//--- dv/pathOramBackend_chk.sv
//--------------------------------------------------------------------
// Protocol checker for the Path ORAM backend
// Valid stability under back-pressure and stash occupancy bound
//--------------------------------------------------------------------
`timescale 1ns/1ns
`include "oram_config.svh"

module pathOramBackend_chk (
	input logic               Clock,
	input logic               rstN,
	input oramPkg::dramCmdT   dramCmd,
	input logic               dramCmdValid,
	input logic               dramCmdReady,
	input oramPkg::bucketT    dramWriteData,
	input logic               dramWriteValid,
	input logic               dramWriteReady,
	input oramPkg::blockDataT loadData,
	input logic               loadValid,
	input logic               loadReady,
	input oramPkg::stashIdxT  occupancy
);
	int unsigned failCount;

	initial failCount = 0;

	cmdHold: assert property (@(posedge Clock) disable iff (!rstN)
		dramCmdValid && !dramCmdReady |=> dramCmdValid && $stable(dramCmd))
		else begin
			$error("DRAM command dropped or changed before acceptance");
			failCount++;
		end

	writeHold: assert property (@(posedge Clock) disable iff (!rstN)
		dramWriteValid && !dramWriteReady |=> dramWriteValid && $stable(dramWriteData))
		else begin
			$error("DRAM write data dropped or changed before acceptance");
			failCount++;
		end

	loadHold: assert property (@(posedge Clock) disable iff (!rstN)
		loadValid && !loadReady |=> loadValid && $stable(loadData))
		else begin
			$error("Load data dropped or changed before acceptance");
			failCount++;
		end

	// A full stash has no room for the next insert
	stashBound: assert property (@(posedge Clock) disable iff (!rstN)
		occupancy < oramPkg::stashIdxT'(`ORAM_STASH))
		else begin
			$error("Stash reached its full capacity");
			failCount++;
		end
endmodule

bind pathOramBackend pathOramBackend_chk u_chk (
	.Clock          (Clock),
	.rstN           (rstN),
	.dramCmd        (dramCmd),
	.dramCmdValid   (dramCmdValid),
	.dramCmdReady   (dramCmdReady),
	.dramWriteData  (dramWriteData),
	.dramWriteValid (dramWriteValid),
	.dramWriteReady (dramWriteReady),
	.loadData       (loadData),
	.loadValid      (loadValid),
	.loadReady      (loadReady),
	.occupancy      (u_backendInner.stashOccupancy)
);

//--- dv/pathOramBackendTb.sv
//--------------------------------------------------------------------
// Path ORAM backend testbench
// Random accesses against a position map and reference memory
//--------------------------------------------------------------------
`timescale 1ns/1ns
`include "oram_config.svh"

module pathOramBackendTb;
	import oramPkg::*;

	localparam int NumAcc = 300;
	localparam int NumAddr = 16;
	localparam int PathLen = `ORAM_L + 1;
	// Per-access budget plus the init sweep and reset
	localparam int TimeoutCycles = NumAcc * 200 + `ORAM_BUCKETS * 20 + 10;

	logic      Clock;
	logic      rstN;
	beCmdE     cmd;
	pAddrT     pAddr;
	leafT      currentLeaf;
	leafT      remappedLeaf;
	logic      cmdValid;
	logic      cmdReady;
	blockDataT loadData;
	logic      loadValid;
	logic      loadReady;
	blockDataT storeData;
	logic      storeValid;
	logic      storeReady;
	dramCmdT   dramCmd;
	logic      dramCmdValid;
	logic      dramCmdReady;
	bucketT    dramReadData;
	logic      dramReadValid;
	logic      dramReadReady;
	bucketT    dramWriteData;
	logic      dramWriteValid;
	logic      dramWriteReady;

	integer      seed;
	blockDataT   refMem [NumAddr];
	leafT        posMap [NumAddr];
	dramCmdT     cmdLog [$];
	int unsigned cycleCnt;

	tbClock u_tbClock (.Clock(Clock));

	dramModel #(.Seed(32'h794c)) u_dramModel (.*);

	pathOramBackend u_pathOramBackend (.*);

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic expectEq(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			abortRun($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	// Heap index of the path bucket at a level, walking down from the root
	function automatic bucketAddrT pathBucket(input leafT leaf, input int level);
		int b;
		b = 0;
		for (int l = 1; l <= level; l++) begin
			b = 2 * b + 1 + int'(leaf[`ORAM_L - l]);
		end
		return bucketAddrT'(b);
	endfunction

	task automatic waitIdle();
		do begin
			@(posedge Clock);
		end while (!cmdReady);
	endtask

	task automatic checkInitSweep();
		expectEq("init dramCmd count", cmdLog.size(), `ORAM_BUCKETS);
		for (int b = 0; b < `ORAM_BUCKETS; b++) begin
			expectEq("init dramCmd", cmdLog[b], {1'b1, bucketAddrT'(b)});
		end
		cmdLog.delete();
	endtask

	// Reads root to leaf, then writes leaf to root
	task automatic checkPathCmds(input leafT leaf);
		expectEq("dramCmd count", cmdLog.size(), 2 * PathLen);
		for (int l = 0; l < PathLen; l++) begin
			expectEq("dramCmd read", cmdLog[l], {1'b0, pathBucket(leaf, l)});
			expectEq("dramCmd write", cmdLog[PathLen + l], {1'b1, pathBucket(leaf, `ORAM_L - l)});
		end
		cmdLog.delete();
	endtask

	task automatic runAccess();
		pAddrT     addr;
		beCmdE     kind;
		leafT      oldLeaf;
		leafT      nextLeaf;
		blockDataT data;
		logic      fired;
		addr     = pAddrT'($unsigned($random(seed)) % NumAddr);
		kind     = beCmdE'($random(seed) & 1);
		nextLeaf = leafT'($random(seed));
		data     = blockDataT'($random(seed));
		oldLeaf  = posMap[addr];

		cmd          = kind;
		pAddr        = addr;
		currentLeaf  = oldLeaf;
		remappedLeaf = nextLeaf;
		cmdValid     = 1'b1;
		if (kind == cmdWrite) begin
			storeData  = data;
			storeValid = 1'b1;
		end
		waitIdle();
		#2;
		cmdValid = 1'b0;

		// Load or store transfer
		fired = 1'b0;
		while (!fired) begin
			@(posedge Clock);
			if (kind == cmdRead) begin
				fired = loadValid && loadReady;
				if (fired) begin
					expectEq("loadData", loadData, refMem[addr]);
				end
			end else begin
				fired = storeValid && storeReady;
			end
			#2;
			loadReady = 1'($random(seed));
		end
		storeValid = 1'b0;
		if (kind == cmdWrite) begin
			refMem[addr] = data;
		end
		posMap[addr] = nextLeaf;

		// Access ends when cmdReady comes back
		waitIdle();
		#2;
		checkPathCmds(oldLeaf);
	endtask

	//------------------------------------------------------------------
	// Monitors
	//------------------------------------------------------------------

	always @(posedge Clock) begin
		if (rstN === 1'b1 && dramCmdValid && dramCmdReady) begin
			cmdLog.push_back(dramCmd);
		end
	end

	always @(posedge Clock) begin
		cycleCnt++;
		if (cycleCnt >= TimeoutCycles) begin
			abortRun($sformatf("Timeout after %0d cycles, accesses did not complete", cycleCnt));
		end else if (u_pathOramBackend.u_chk.failCount != 0) begin
			abortRun("Protocol checker reported an assertion failure");
		end
	end

	//------------------------------------------------------------------
	// Stimulus
	//------------------------------------------------------------------

	initial begin
		seed         = 32'h794c;
		cycleCnt     = 0;
		rstN         = 1'b0;
		cmd          = cmdRead;
		pAddr        = '0;
		currentLeaf  = '0;
		remappedLeaf = '0;
		cmdValid     = 1'b0;
		loadReady    = 1'b0;
		storeData    = '0;
		storeValid   = 1'b0;
		// Unwritten blocks read as zero and start on a random leaf
		for (int a = 0; a < NumAddr; a++) begin
			refMem[a] = '0;
			posMap[a] = leafT'($random(seed));
		end

		repeat (5) @(posedge Clock);
		#2;
		rstN = 1'b1;
		@(posedge Clock);
		expectEq("cmdReady", cmdReady, 1'b0);
		expectEq("loadValid", loadValid, 1'b0);
		expectEq("storeReady", storeReady, 1'b0);
		expectEq("dramCmdValid", dramCmdValid, 1'b0);
		expectEq("dramWriteValid", dramWriteValid, 1'b0);
		waitIdle();
		#2;
		checkInitSweep();

		for (int n = 0; n < NumAcc; n++) begin
			runAccess();
		end

		if (u_pathOramBackend.u_chk.failCount == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			abortRun("Protocol checker reported an assertion failure");
		end
	end
endmodule

//--- filelist.f
+incdir+design
design/oramPkg.sv
design/oramStash.sv
design/backendInner.sv
design/bucketCipher.sv
design/pathOramBackend.sv
dv/tbClock.sv
dv/dramModel.sv
dv/pathOramBackend_chk.sv
dv/pathOramBackendTb.sv

//--- Makefile
# Verilator build and run for the Path ORAM backend testbench

VERILATOR ?= verilator
TOP       ?= pathOramBackendTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(SIM) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)
